//--- hw/mmu_params.svh
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// TLB geometry
`define MMU_TLB_ENTRIES 16
`define MMU_IDX_W       4
`define MMU_VPN2_W      19
`define MMU_ASID_W      8
`define MMU_PFN_W       20
`define MMU_HI_W        27  // {vpn2, asid}
`define MMU_LO_W        23  // {pfn, uncached, dirty, valid}

// ~~~~~~~~~~~~~~~~~~~~
// Fixed segment bases
`define MMU_KSEG0_BASE  32'h8000_0000
`define MMU_KSEG1_BASE  32'hA000_0000

// ~~~~~~~~~~~~~~~~~~~~
// Maintenance op codes
`define MMU_OP_WRITE    2'd0
`define MMU_OP_PROBE    2'd1
`define MMU_OP_READ     2'd2

`endif

//--- hw/mmu_pkg.sv
`include "mmu_params.svh"

package mmu_pkg;

  // One virtual address word seen as segment or as page
  typedef union packed {
    struct packed {
      logic [2:0]  seg;          // Top bits pick kuseg/kseg0/kseg1/kseg2-3
      logic [28:0] off;
    } s;
    struct packed {
      logic [`MMU_VPN2_W-1:0] vpn2;  // Page pair number
      logic                   odd;   // Selects lo1 over lo0
      logic [11:0]            off;   // 4 KB page offset
    } p;
  } va_u;

endpackage

//--- hw/xlat_if.sv
interface xlat_if;

  // Segment decoder results
  logic        mapped;
  logic        illegal;
  logic        seg_uncached;
  logic [31:0] direct_pa;

  // TLB lookup results
  logic        hit;
  logic        valid;
  logic        dirty;
  logic        tlb_uncached;
  logic [31:0] tlb_pa;

  modport seg (
    output mapped, illegal, seg_uncached, direct_pa
  );

  modport tlb (
    output hit, valid, dirty, tlb_uncached, tlb_pa
  );

  modport res (
    input mapped, illegal, seg_uncached, direct_pa,
    input hit, valid, dirty, tlb_uncached, tlb_pa
  );

endinterface

//--- hw/seg_decode.sv
`include "mmu_params.svh"

module seg_decode
  import mmu_pkg::*;
(
  input  va_u   vaddr_i,
  input  logic  user_mode_i,
  input  logic  kseg0_uncached_i,
  xlat_if.seg   xl_o
);

  logic [31:0] va_word;
  logic        kseg0;
  logic        kseg1;
  logic        kernel;

  assign va_word = vaddr_i;

  // ~~~~~~~~~~~~~~~~~~~~
  // Segment classification
  assign kernel = vaddr_i.s.seg[2];              // Bit 31 set
  assign kseg0  = (vaddr_i.s.seg == 3'b100);
  assign kseg1  = (vaddr_i.s.seg == 3'b101);

  // kuseg and kseg2/3 go through the TLB
  assign xl_o.mapped = !kseg0 && !kseg1;

  assign xl_o.seg_uncached = kseg1 || (kseg0 && kseg0_uncached_i);

  // ~~~~~~~~~~~~~~~~~~~~
  // Direct physical address
  always_comb begin
    if (kseg1) begin
      xl_o.direct_pa = va_word - `MMU_KSEG1_BASE;
    end else begin
      xl_o.direct_pa = va_word - `MMU_KSEG0_BASE;  // Only meaningful for kseg0
    end
  end

  // User mode only reaches kuseg
  assign xl_o.illegal = user_mode_i && kernel;

endmodule

//--- hw/tlb_array.sv
`include "mmu_params.svh"

module tlb_array
  import mmu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic [`MMU_ASID_W-1:0] asid_i,
  input  va_u                    inst_va_i,
  input  va_u                    data_va_i,
  xlat_if.tlb                    inst_xl_o,
  xlat_if.tlb                    data_xl_o,
  input  logic                   req_i,
  output logic                   ack_o,
  input  logic [1:0]             op_i,
  input  logic [`MMU_IDX_W-1:0]  tlb_index_i,
  input  logic [`MMU_HI_W-1:0]   tlb_hi_i,
  input  logic [`MMU_LO_W-1:0]   tlb_lo0_i,
  input  logic [`MMU_LO_W-1:0]   tlb_lo1_i,
  input  logic                   tlb_global_i,
  output logic [31:0]            probe_result_o,
  output logic [`MMU_HI_W-1:0]   read_hi_o,
  output logic [`MMU_LO_W-1:0]   read_lo0_o,
  output logic [`MMU_LO_W-1:0]   read_lo1_o,
  output logic                   read_global_o
);

  // ~~~~~~~~~~~~~~~~~~~~
  // Entry storage
  logic [`MMU_HI_W-1:0]        hi_q  [`MMU_TLB_ENTRIES];
  logic [`MMU_LO_W-1:0]        lo0_q [`MMU_TLB_ENTRIES];
  logic [`MMU_LO_W-1:0]        lo1_q [`MMU_TLB_ENTRIES];
  logic [`MMU_TLB_ENTRIES-1:0] global_q;
  logic [`MMU_TLB_ENTRIES-1:0] live_q;   // Entry written since reset

  logic        ack_q;
  logic        fire;
  logic [31:0] probe_word;

  function automatic logic entry_match(input int idx,
                                       input logic [`MMU_VPN2_W-1:0] vpn2,
                                       input logic [`MMU_ASID_W-1:0] asid);
    return live_q[idx]
        && (hi_q[idx][`MMU_HI_W-1 -: `MMU_VPN2_W] == vpn2)
        && (global_q[idx] || (hi_q[idx][`MMU_ASID_W-1:0] == asid));
  endfunction

  // Packs {hit, valid, dirty, uncached, pa}
  function automatic logic [35:0] lookup(input va_u va);
    logic                 hit;
    logic [`MMU_LO_W-1:0] lo;
    hit = 1'b0;
    lo  = '0;
    for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--) begin
      if (entry_match(i, va.p.vpn2, asid_i)) begin
        hit = 1'b1;
        lo  = va.p.odd ? lo1_q[i] : lo0_q[i];
      end
    end
    return {hit, lo[0], lo[1], lo[2], lo[`MMU_LO_W-1 -: `MMU_PFN_W], va.p.off};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // Dual-port lookup
  always_comb begin
    {inst_xl_o.hit, inst_xl_o.valid, inst_xl_o.dirty,
     inst_xl_o.tlb_uncached, inst_xl_o.tlb_pa} = lookup(inst_va_i);
  end

  always_comb begin
    {data_xl_o.hit, data_xl_o.valid, data_xl_o.dirty,
     data_xl_o.tlb_uncached, data_xl_o.tlb_pa} = lookup(data_va_i);
  end

  // Probe priority encoder where the lowest index wins
  always_comb begin
    probe_word = 32'h8000_0000;
    for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--) begin
      if (entry_match(i, tlb_hi_i[`MMU_HI_W-1 -: `MMU_VPN2_W], tlb_hi_i[`MMU_ASID_W-1:0])) begin
        probe_word = {1'b0, {(31 - `MMU_IDX_W){1'b0}}, i[`MMU_IDX_W-1:0]};
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Four-phase maintenance engine
  assign fire = req_i && !ack_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q    <= 1'b0;
      live_q   <= '0;
      global_q <= '0;
    end else begin
      if (fire) begin
        ack_q <= 1'b1;
      end else if (!req_i) begin
        ack_q <= 1'b0;              // Return to idle
      end
      if (fire && op_i == `MMU_OP_WRITE) begin
        live_q[tlb_index_i]   <= 1'b1;
        global_q[tlb_index_i] <= tlb_global_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      case (op_i)
        `MMU_OP_WRITE: begin
          hi_q[tlb_index_i]  <= tlb_hi_i;
          lo0_q[tlb_index_i] <= tlb_lo0_i;
          lo1_q[tlb_index_i] <= tlb_lo1_i;
        end
        `MMU_OP_PROBE: probe_result_o <= probe_word;
        `MMU_OP_READ: begin
          read_hi_o     <= hi_q[tlb_index_i];
          read_lo0_o    <= lo0_q[tlb_index_i];
          read_lo1_o    <= lo1_q[tlb_index_i];
          read_global_o <= global_q[tlb_index_i];
        end
        default: ;                  // Unused code is only acked
      endcase
    end
  end

  assign ack_o = ack_q;

endmodule

//--- hw/xlat_result.sv
module xlat_result (
  input  logic        en_i,
  input  logic        we_i,
  xlat_if.res         xl_i,
  output logic [31:0] pa_o,
  output logic        uncached_o,
  output logic        exp_illegal_o,
  output logic        exp_miss_o,
  output logic        exp_invalid_o,
  output logic        exp_modify_o
);

  logic mapped_ok;     // Enabled, legal and going through the TLB
  logic page_ok;       // Hit on a valid page

  // ~~~~~~~~~~~~~~~~~~~~
  // Address and attribute select
  always_comb begin
    if (xl_i.mapped) begin
      pa_o       = xl_i.tlb_pa;
      uncached_o = xl_i.tlb_uncached;
    end else begin
      pa_o       = xl_i.direct_pa;
      uncached_o = xl_i.seg_uncached;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Exception priority from illegal down to modify
  assign mapped_ok = en_i && !xl_i.illegal && xl_i.mapped;
  assign page_ok   = xl_i.hit && xl_i.valid;

  assign exp_illegal_o = en_i && xl_i.illegal;
  assign exp_miss_o    = mapped_ok && !xl_i.hit;
  assign exp_invalid_o = mapped_ok && xl_i.hit && !xl_i.valid;
  assign exp_modify_o  = mapped_ok && page_ok && !xl_i.dirty && we_i;  // Store to clean page

endmodule

//--- hw/mmu_top.sv
`include "mmu_params.svh"

module mmu_top (
  input  logic                   clk,
  input  logic                   rst_i,
  // Instruction port
  input  logic [31:0]            inst_va_i,
  input  logic                   inst_en_i,
  output logic [31:0]            inst_pa_o,
  output logic                   inst_uncached_o,
  output logic                   inst_exp_illegal_o,
  output logic                   inst_exp_miss_o,
  output logic                   inst_exp_invalid_o,
  // Data port
  input  logic [31:0]            data_va_i,
  input  logic                   data_en_i,
  input  logic                   data_we_i,
  output logic [31:0]            data_pa_o,
  output logic                   data_uncached_o,
  output logic                   data_exp_illegal_o,
  output logic                   data_exp_miss_o,
  output logic                   data_exp_invalid_o,
  output logic                   data_exp_modify_o,
  // Mode and address space
  input  logic                   user_mode_i,
  input  logic                   kseg0_uncached_i,
  input  logic [`MMU_ASID_W-1:0] asid_i,
  // TLB maintenance
  input  logic                   req_i,
  output logic                   ack_o,
  input  logic [1:0]             op_i,
  input  logic [`MMU_IDX_W-1:0]  tlb_index_i,
  input  logic [`MMU_HI_W-1:0]   tlb_hi_i,
  input  logic [`MMU_LO_W-1:0]   tlb_lo0_i,
  input  logic [`MMU_LO_W-1:0]   tlb_lo1_i,
  input  logic                   tlb_global_i,
  output logic [31:0]            probe_result_o,
  output logic [`MMU_HI_W-1:0]   read_hi_o,
  output logic [`MMU_LO_W-1:0]   read_lo0_o,
  output logic [`MMU_LO_W-1:0]   read_lo1_o,
  output logic                   read_global_o
);

  xlat_if inst_xl ();
  xlat_if data_xl ();

  // ~~~~~~~~~~~~~~~~~~~~
  // Segment decoders
  seg_decode u_inst_seg (
    .vaddr_i          (inst_va_i),
    .user_mode_i      (user_mode_i),
    .kseg0_uncached_i (kseg0_uncached_i),
    .xl_o             (inst_xl.seg)
  );

  seg_decode u_data_seg (
    .vaddr_i          (data_va_i),
    .user_mode_i      (user_mode_i),
    .kseg0_uncached_i (kseg0_uncached_i),
    .xl_o             (data_xl.seg)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Shared TLB
  tlb_array u_tlb (
    .clk            (clk),
    .rst_i          (rst_i),
    .asid_i         (asid_i),
    .inst_va_i      (inst_va_i),
    .data_va_i      (data_va_i),
    .inst_xl_o      (inst_xl.tlb),
    .data_xl_o      (data_xl.tlb),
    .req_i          (req_i),
    .ack_o          (ack_o),
    .op_i           (op_i),
    .tlb_index_i    (tlb_index_i),
    .tlb_hi_i       (tlb_hi_i),
    .tlb_lo0_i      (tlb_lo0_i),
    .tlb_lo1_i      (tlb_lo1_i),
    .tlb_global_i   (tlb_global_i),
    .probe_result_o (probe_result_o),
    .read_hi_o      (read_hi_o),
    .read_lo0_o     (read_lo0_o),
    .read_lo1_o     (read_lo1_o),
    .read_global_o  (read_global_o)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Result mergers
  xlat_result u_inst_res (
    .en_i          (inst_en_i),
    .we_i          (1'b0),          // Fetches never write
    .xl_i          (inst_xl.res),
    .pa_o          (inst_pa_o),
    .uncached_o    (inst_uncached_o),
    .exp_illegal_o (inst_exp_illegal_o),
    .exp_miss_o    (inst_exp_miss_o),
    .exp_invalid_o (inst_exp_invalid_o),
    .exp_modify_o  ()
  );

  xlat_result u_data_res (
    .en_i          (data_en_i),
    .we_i          (data_we_i),
    .xl_i          (data_xl.res),
    .pa_o          (data_pa_o),
    .uncached_o    (data_uncached_o),
    .exp_illegal_o (data_exp_illegal_o),
    .exp_miss_o    (data_exp_miss_o),
    .exp_invalid_o (data_exp_invalid_o),
    .exp_modify_o  (data_exp_modify_o)
  );

endmodule

//--- test/mmu_checker.sv
module mmu_checker (
  input logic       clk,
  input logic       rst_i,
  input logic       req_i,
  input logic       ack_i,
  input logic [2:0] inst_exp_i,   // {illegal, miss, invalid}
  input logic [3:0] data_exp_i    // {illegal, miss, invalid, modify}
);

  // ~~~~~~~~~~~~~~~~~~~~
  // Maintenance handshake
  a_ack_after_reset: assert property (@(posedge clk) rst_i |=> !ack_i)
    else $error("ack_o is high in the cycle after reset");

  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (rst_i) $rose(ack_i) |-> $past(req_i))
    else $error("ack_o rose without a pending request");

  // ~~~~~~~~~~~~~~~~~~~~
  // At most one exception per port
  a_inst_exp_onehot: assert property (@(posedge clk) $onehot0(inst_exp_i))
    else $error("More than one instruction exception is active");

  a_data_exp_onehot: assert property (@(posedge clk) $onehot0(data_exp_i))
    else $error("More than one data exception is active");

endmodule

bind mmu_top mmu_checker u_checker (
  .clk        (clk),
  .rst_i      (rst_i),
  .req_i      (req_i),
  .ack_i      (ack_o),
  .inst_exp_i ({inst_exp_illegal_o, inst_exp_miss_o, inst_exp_invalid_o}),
  .data_exp_i ({data_exp_illegal_o, data_exp_miss_o, data_exp_invalid_o, data_exp_modify_o})
);

//--- test/mmu_tb.sv
`include "mmu_params.svh"

module mmu_tb
  import mmu_pkg::*;
();

  localparam int PERIOD  = 40;
  localparam int DRV_DLY = 4;
  localparam int TMO     = 20;   // Cycles allowed per handshake phase
  localparam int IDX_W   = `MMU_IDX_W;
  localparam int VPN2_W  = `MMU_VPN2_W;
  localparam int HI_W    = `MMU_HI_W;
  localparam int LO_W    = `MMU_LO_W;

  logic                   clk;
  logic                   rst_i;
  logic [31:0]            inst_va_i, data_va_i, inst_pa_o, data_pa_o, probe_result_o;
  logic                   inst_en_i, data_en_i, data_we_i, user_mode_i, kseg0_uncached_i;
  logic                   inst_uncached_o, inst_exp_illegal_o, inst_exp_miss_o;
  logic                   inst_exp_invalid_o, data_uncached_o, data_exp_illegal_o;
  logic                   data_exp_miss_o, data_exp_invalid_o, data_exp_modify_o;
  logic [`MMU_ASID_W-1:0] asid_i;
  logic                   req_i, ack_o, tlb_global_i, read_global_o;
  logic [1:0]             op_i;
  logic [`MMU_IDX_W-1:0]  tlb_index_i;
  logic [`MMU_HI_W-1:0]   tlb_hi_i, read_hi_o;
  logic [`MMU_LO_W-1:0]   tlb_lo0_i, tlb_lo1_i, read_lo0_o, read_lo1_o;

  // ~~~~~~~~~~~~~~~~~~~~
  // Shadow TLB
  logic [`MMU_HI_W-1:0]        sh_hi  [`MMU_TLB_ENTRIES];
  logic [`MMU_LO_W-1:0]        sh_lo0 [`MMU_TLB_ENTRIES];
  logic [`MMU_LO_W-1:0]        sh_lo1 [`MMU_TLB_ENTRIES];
  logic [`MMU_TLB_ENTRIES-1:0] sh_g;
  logic [`MMU_TLB_ENTRIES-1:0] sh_live = '0;

  logic cmp_on     = 1'b0;   // Translation outputs are compared at negedge
  int   value_errs = 0;
  int   tmo_errs   = 0;

  mmu_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Compare tasks
  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_entry(input string name, input logic [`MMU_HI_W-1:0] exp,
                             input logic [`MMU_HI_W-1:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d wrong values, %0d handshake timeouts", value_errs, tmo_errs);
    if (value_errs == 0 && tmo_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Reference model
  function automatic logic shadow_match(input int i, input logic [`MMU_VPN2_W-1:0] vpn2,
                                        input logic [`MMU_ASID_W-1:0] asid);
    return sh_live[i] && sh_hi[i][`MMU_HI_W-1 -: `MMU_VPN2_W] == vpn2
        && (sh_g[i] || sh_hi[i][`MMU_ASID_W-1:0] == asid);
  endfunction

  // Exceptions come back as {illegal, miss, invalid, modify}
  function automatic void ref_xlat(input va_u va, input logic user, input logic k0_unc,
                                   input logic [`MMU_ASID_W-1:0] asid, input logic en,
                                   input logic we, output logic [31:0] pa,
                                   output logic unc, output logic [3:0] exc,
                                   output logic known);
    logic                 mapped;
    logic                 illegal;
    logic                 hit;
    logic [`MMU_LO_W-1:0] lo;
    mapped  = va.s.seg != 3'b100 && va.s.seg != 3'b101;
    illegal = user && va.s.seg[2];
    hit     = 1'b0;
    lo      = '0;
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      if (!hit && shadow_match(i, va.p.vpn2, asid)) begin
        hit = 1'b1;
        lo  = va.p.odd ? sh_lo1[i] : sh_lo0[i];
      end
    end
    if (mapped) begin
      pa  = {lo[`MMU_LO_W-1 -: `MMU_PFN_W], va.p.off};
      unc = lo[2];
    end else begin
      pa  = {3'b000, va.s.off};               // Both direct segments start at physical 0
      unc = (va.s.seg == 3'b101) || k0_unc;
    end
    known = !illegal && (hit || !mapped);   // Address undefined on a miss or illegal access
    exc   = 4'b0000;
    if (en && illegal) exc = 4'b1000;
    else if (en && mapped && !hit) exc = 4'b0100;
    else if (en && mapped && !lo[0]) exc = 4'b0010;
    else if (en && mapped && we && !lo[1]) exc = 4'b0001;
  endfunction

  function automatic logic [31:0] ref_probe(input logic [`MMU_HI_W-1:0] hi);
    logic [31:0] res;
    res = 32'h8000_0000;
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      if (res[31] && shadow_match(i, hi[`MMU_HI_W-1 -: `MMU_VPN2_W], hi[`MMU_ASID_W-1:0]))
        res = i;
    end
    return res;
  endfunction

  initial begin : compare
    logic [31:0] pa;
    logic        unc;
    logic [3:0]  exc;
    logic        known;
    forever begin
      @(negedge clk);
      if (cmp_on) begin
        ref_xlat(inst_va_i, user_mode_i, kseg0_uncached_i, asid_i, inst_en_i, 1'b0,
                 pa, unc, exc, known);
        if (known) begin
          check_word("inst_pa_o", pa, inst_pa_o);
          check_flag("inst_uncached_o", unc, inst_uncached_o);
        end
        check_flag("inst_exp_illegal_o", exc[3], inst_exp_illegal_o);
        check_flag("inst_exp_miss_o", exc[2], inst_exp_miss_o);
        check_flag("inst_exp_invalid_o", exc[1], inst_exp_invalid_o);
        ref_xlat(data_va_i, user_mode_i, kseg0_uncached_i, asid_i, data_en_i, data_we_i,
                 pa, unc, exc, known);
        if (known) begin
          check_word("data_pa_o", pa, data_pa_o);
          check_flag("data_uncached_o", unc, data_uncached_o);
        end
        check_flag("data_exp_illegal_o", exc[3], data_exp_illegal_o);
        check_flag("data_exp_miss_o", exc[2], data_exp_miss_o);
        check_flag("data_exp_invalid_o", exc[1], data_exp_invalid_o);
        check_flag("data_exp_modify_o", exc[0], data_exp_modify_o);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers
  task automatic next_cycle();
    @(posedge clk);
    #DRV_DLY;
  endtask

  task automatic wait_ack(input logic level);
    int cnt;
    cnt = 0;
    while (ack_o !== level && cnt < TMO) begin
      next_cycle();
      cnt++;
    end
    if (ack_o !== level) begin
      $display("Handshake stalled: ack_o did not reach %b within %0d cycles", level, TMO);
      tmo_errs++;
      finish_run();
    end
  endtask

  // Four-phase request with results checked while ack_o is high
  task automatic run_op(input logic [1:0] op, input logic [`MMU_IDX_W-1:0] idx,
                        input logic [`MMU_HI_W-1:0] hi);
    cmp_on      = 1'b0;
    op_i        = op;
    tlb_index_i = idx;
    tlb_hi_i    = hi;
    req_i       = 1'b1;
    wait_ack(1'b1);
    case (op)
      `MMU_OP_WRITE: begin
        sh_hi[idx]   = hi;
        sh_lo0[idx]  = tlb_lo0_i;
        sh_lo1[idx]  = tlb_lo1_i;
        sh_g[idx]    = tlb_global_i;
        sh_live[idx] = 1'b1;
      end
      `MMU_OP_PROBE: check_word("probe_result_o", ref_probe(hi), probe_result_o);
      default: begin
        check_entry("read_hi_o", sh_hi[idx], read_hi_o);
        check_entry("read_lo0_o", HI_W'(sh_lo0[idx]), HI_W'(read_lo0_o));
        check_entry("read_lo1_o", HI_W'(sh_lo1[idx]), HI_W'(read_lo1_o));
        check_flag("read_global_o", sh_g[idx], read_global_o);
      end
    endcase
    req_i = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic write_rand(input logic [`MMU_IDX_W-1:0] idx,
                            input logic [`MMU_ASID_W-1:0] asid);
    logic [`MMU_VPN2_W-1:0] vpn2;
    vpn2 = VPN2_W'($urandom);
    vpn2[IDX_W-1:0] = idx;                       // Index in the low bits keeps VPN2s unique
    if (vpn2[VPN2_W-1 -: 2] == 2'b10) vpn2[VPN2_W-2] = 1'b1;  // Stay out of kseg0/1
    tlb_lo0_i    = LO_W'($urandom);
    tlb_lo1_i    = LO_W'($urandom);
    tlb_global_i = ($urandom % 4) == 0;
    run_op(`MMU_OP_WRITE, idx, {vpn2, asid});
  endtask

  function automatic logic [31:0] mapped_va();
    logic [31:0] va;
    va = $urandom;
    if (va[31]) va[30] = 1'b1;                   // kseg2/3 rather than kseg0/1
    return va;
  endfunction

  function automatic logic [31:0] entry_va(input logic [`MMU_IDX_W-1:0] idx);
    logic [31:0] va;
    va = $urandom;
    va[31 -: `MMU_VPN2_W] = sh_hi[idx][`MMU_HI_W-1 -: `MMU_VPN2_W];
    return va;
  endfunction

  task automatic apply(input logic [31:0] iva, input logic [31:0] dva, input logic en,
                       input logic we);
    inst_va_i = iva;
    data_va_i = dva;
    inst_en_i = en;
    data_en_i = en;
    data_we_i = we;
    cmp_on    = 1'b1;
    next_cycle();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  initial begin : stimulus
    void'($urandom(74));
    {req_i, op_i, tlb_index_i, tlb_hi_i, tlb_lo0_i, tlb_lo1_i, tlb_global_i} = '0;
    {inst_va_i, data_va_i, inst_en_i, data_en_i, data_we_i} = '0;
    {user_mode_i, kseg0_uncached_i, asid_i} = '0;
    rst_i = 1'b1;
    repeat (16) next_cycle();
    rst_i = 1'b0;
    next_cycle();
    check_flag("ack_o", 1'b0, ack_o);
    repeat (20) apply(mapped_va(), mapped_va(), 1'b1, 1'($urandom));   // Empty TLB misses
    repeat (40) begin
      kseg0_uncached_i = 1'($urandom);
      apply({2'b10, 30'($urandom)}, {2'b10, 30'($urandom)}, 1'b1, 1'($urandom));
    end
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      write_rand(IDX_W'(i), ($urandom % 2) ? 8'h5A : 8'h3C);
    end
    repeat (150) begin
      asid_i = ($urandom % 2) ? 8'h5A : 8'h3C;   // Mismatch unless the entry is global
      apply(entry_va(IDX_W'($urandom)), entry_va(IDX_W'($urandom)), 1'b1, 1'($urandom));
    end
    user_mode_i = 1'b1;
    repeat (30) begin
      apply(32'h8000_0000 | $urandom, entry_va(IDX_W'($urandom)), 1'b1, 1'($urandom));
    end
    repeat (30) begin
      user_mode_i = 1'($urandom);
      apply($urandom, entry_va(IDX_W'($urandom)), 1'b0, 1'($urandom));
    end
    user_mode_i = 1'b0;
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      run_op(`MMU_OP_PROBE, IDX_W'(i), sh_hi[i]);
      // Bit above the index field makes this VPN2 absent
      run_op(`MMU_OP_PROBE, IDX_W'(i), sh_hi[i] ^ (HI_W'(1) << (`MMU_ASID_W + IDX_W)));
      run_op(`MMU_OP_READ, IDX_W'(i), '0);
    end
    finish_run();
  end

endmodule

//--- sources.f
+incdir+hw
hw/mmu_pkg.sv
hw/xlat_if.sv
hw/seg_decode.sv
hw/tlb_array.sv
hw/xlat_result.sv
hw/mmu_top.sv
test/mmu_checker.sv
test/mmu_tb.sv

//--- Bender.yml
package:
  name: mmu

sources:
  - include_dirs:
      - hw
    files:
      - hw/mmu_pkg.sv
      - hw/xlat_if.sv
      - hw/seg_decode.sv
      - hw/tlb_array.sv
      - hw/xlat_result.sv
      - hw/mmu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/mmu_checker.sv
      - test/mmu_tb.sv
